//--- design/lc4_pkg.sv
// Shared types, opcodes and stage payloads for the LC4 five-stage pipeline
// Every stage pulls these in with a wildcard import
`default_nettype none

package lc4_pkg;

  typedef logic [15:0] word_t;     // Data or address word
  typedef logic [15:0] insn_t;     // Instruction word
  typedef logic [2:0]  reg_idx_t;  // R0..R7
  typedef logic [2:0]  nzp_t;      // {n, z, p}

  localparam int NUM_REGS = 8;

  // Opcode field, insn[15:12]
  localparam logic [3:0] OPC_BR      = 4'b0000;
  localparam logic [3:0] OPC_ARITH   = 4'b0001;
  localparam logic [3:0] OPC_LOGIC   = 4'b0101;
  localparam logic [3:0] OPC_LDR     = 4'b0110;
  localparam logic [3:0] OPC_STR     = 4'b0111;
  localparam logic [3:0] OPC_CONST   = 4'b1001;
  localparam logic [3:0] OPC_JMPR    = 4'b1100;  // insn[11] low selects JMPR
  localparam logic [3:0] OPC_HICONST = 4'b1101;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_ADDI, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
    ALU_CONST, ALU_HICONST,
    ALU_ADDR   // Base plus offset for LDR and STR
  } alu_op_e;

  typedef struct packed {
    logic    rs_re;
    logic    rt_re;
    logic    regfile_we;
    logic    nzp_we;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    is_jump;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    insn_t insn;
  } fd_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    insn_t    insn;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    ctrl_t    ctrl;
    word_t    rs_data;
    word_t    rt_data;
  } dx_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    ctrl_t    ctrl;
    word_t    result;      // ALU value or memory address
    word_t    store_data;
  } xm_t;

  // Commit record, also the trace seen at the top level
  typedef struct packed {
    logic     regfile_we;
    reg_idx_t wsel;
    word_t    data;
    logic     nzp_we;
    nzp_t     nzp;
  } wb_t;

  // Condition code of a value about to be written
  function automatic nzp_t nzp_of(input word_t v);
    if (v[15]) return 3'b100;
    else if (v == '0) return 3'b010;
    else return 3'b001;
  endfunction

endpackage

`default_nettype wire

//--- design/lc4_regfile.sv
// Eight-entry register file written from the commit record
// A read of the register being committed returns the new value
`timescale 1ns/100ps
`default_nettype none

module lc4_regfile
  import lc4_pkg::*;
(
  input  wire           gwe,
  input  wire           i_rst_n,
  input  wire reg_idx_t i_rs,
  input  wire reg_idx_t i_rt,
  input  wire wb_t      i_wb,
  output word_t         o_rs_data,
  output word_t         o_rt_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.regfile_we) begin
      regs[i_wb.wsel] <= i_wb.data;
    end
  end

  // Write before read
  assign o_rs_data = (i_wb.regfile_we && i_wb.wsel == i_rs) ? i_wb.data : regs[i_rs];
  assign o_rt_data = (i_wb.regfile_we && i_wb.wsel == i_rt) ? i_wb.data : regs[i_rt];

endmodule

`default_nettype wire

//--- design/lc4_fetch.sv
// Fetch stage: program counter and the fetch-to-decode register
// Holds on a load-use stall, jumps to the execute target on a redirect
`timescale 1ns/100ps
`default_nettype none

module lc4_fetch
  import lc4_pkg::*;
#(
  parameter word_t RESET_PC = 16'h8200
) (
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire        i_stall,
  input  wire        i_redirect,
  input  wire word_t i_target,
  input  wire insn_t i_imem_data,
  output word_t      o_imem_addr,
  output fd_t        o_fd
);

  word_t pc_q;
  logic  fd_valid_q;
  word_t fd_pc_q;
  insn_t fd_insn_q;

  assign o_imem_addr = pc_q;  // Instruction memory reads combinationally
  assign o_fd        = '{valid: fd_valid_q, pc: fd_pc_q, insn: fd_insn_q};

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      pc_q       <= RESET_PC;
      fd_valid_q <= 1'b0;
    end else if (i_redirect) begin
      pc_q       <= i_target;
      fd_valid_q <= 1'b0;  // Kill the wrong-path fetch
    end else if (!i_stall) begin
      pc_q       <= pc_q + 16'd1;
      fd_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge gwe) begin
    if (!i_stall) begin  // Keep the stalled instruction in decode
      fd_pc_q   <= pc_q;
      fd_insn_q <= i_imem_data;
    end
  end

endmodule

`default_nettype wire

//--- design/lc4_decode.sv
// Decode stage: instruction decoder, register read and load-use check
// Sends a bubble to execute on a stall or a redirect
`timescale 1ns/100ps
`default_nettype none

module lc4_decode
  import lc4_pkg::*;
(
  input  wire           gwe,
  input  wire           i_rst_n,
  input  wire fd_t      i_fd,
  input  wire           i_redirect,
  input  wire reg_idx_t i_x_rd,       // Destination of the execute instruction
  input  wire           i_x_is_load,
  input  wire wb_t      i_wb,
  output logic          o_stall,
  output dx_t           o_dx
);

  insn_t    insn;
  ctrl_t    ctrl;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    rs_data;
  word_t    rt_data;
  logic     dx_valid;
  logic     dx_valid_q;
  ctrl_t    dx_ctrl_q;
  word_t    dx_pc_q;
  insn_t    dx_insn_q;
  reg_idx_t dx_rs_q;
  reg_idx_t dx_rt_q;
  reg_idx_t dx_rd_q;
  word_t    dx_rs_data_q;
  word_t    dx_rt_data_q;

  assign insn = i_fd.insn;

  always_comb begin
    ctrl = '0;           // Unknown or dropped opcodes act as NOPs
    rs   = insn[8:6];
    rt   = insn[2:0];
    rd   = insn[11:9];
    case (insn[15:12])
      OPC_BR: ctrl.is_branch = 1'b1;
      OPC_ARITH: begin
        if (insn[5]) begin  // ADD immediate
          ctrl.alu_op     = ALU_ADDI;
          ctrl.rs_re      = 1'b1;
          ctrl.regfile_we = 1'b1;
        end else if (insn[3] == 1'b0) begin  // ADD or SUB, MUL and DIV fall out
          ctrl.alu_op     = insn[4] ? ALU_SUB : ALU_ADD;
          ctrl.rs_re      = 1'b1;
          ctrl.rt_re      = 1'b1;
          ctrl.regfile_we = 1'b1;
        end
      end
      OPC_LOGIC: begin
        if (!insn[5]) begin
          case (insn[4:3])
            2'b00:   ctrl.alu_op = ALU_AND;
            2'b01:   ctrl.alu_op = ALU_NOT;
            2'b10:   ctrl.alu_op = ALU_OR;
            default: ctrl.alu_op = ALU_XOR;
          endcase
          ctrl.rs_re      = 1'b1;
          ctrl.rt_re      = (insn[4:3] != 2'b01);  // NOT has one source
          ctrl.regfile_we = 1'b1;
        end
      end
      OPC_LDR: begin
        ctrl.alu_op     = ALU_ADDR;
        ctrl.rs_re      = 1'b1;
        ctrl.regfile_we = 1'b1;
        ctrl.is_load    = 1'b1;
      end
      OPC_STR: begin
        rt              = insn[11:9];  // Store data sits in the rd field
        ctrl.alu_op     = ALU_ADDR;
        ctrl.rs_re      = 1'b1;
        ctrl.rt_re      = 1'b1;
        ctrl.is_store   = 1'b1;
      end
      OPC_CONST: begin
        ctrl.alu_op     = ALU_CONST;
        ctrl.regfile_we = 1'b1;
      end
      OPC_HICONST: begin
        rs              = insn[11:9];  // Keeps the low byte of Rd
        ctrl.alu_op     = ALU_HICONST;
        ctrl.rs_re      = 1'b1;
        ctrl.regfile_we = 1'b1;
      end
      OPC_JMPR: begin
        ctrl.rs_re   = 1'b1;
        ctrl.is_jump = !insn[11];
      end
      default: ;
    endcase
    ctrl.nzp_we = ctrl.regfile_we;  // Every register write sets NZP
  end

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs      (rs),
    .i_rt      (rt),
    .i_wb      (i_wb),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  // Load in execute feeds a source here, store data is bypassed later
  assign o_stall = i_fd.valid && i_x_is_load &&
                   ((ctrl.rs_re && rs == i_x_rd) ||
                    (ctrl.rt_re && !ctrl.is_store && rt == i_x_rd));

  assign dx_valid = i_fd.valid && !o_stall && !i_redirect;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      dx_valid_q <= 1'b0;
      dx_ctrl_q  <= '0;
    end else begin
      dx_valid_q <= dx_valid;
      dx_ctrl_q  <= dx_valid ? ctrl : '0;  // Bubble carries no control
    end
  end

  always_ff @(posedge gwe) begin
    dx_pc_q      <= i_fd.pc;
    dx_insn_q    <= insn;
    dx_rs_q      <= rs;
    dx_rt_q      <= rt;
    dx_rd_q      <= rd;
    dx_rs_data_q <= rs_data;
    dx_rt_data_q <= rt_data;
  end

  assign o_dx = '{valid: dx_valid_q, pc: dx_pc_q, insn: dx_insn_q,
                  rs: dx_rs_q, rt: dx_rt_q, rd: dx_rd_q, ctrl: dx_ctrl_q,
                  rs_data: dx_rs_data_q, rt_data: dx_rt_data_q};

endmodule

`default_nettype wire

//--- design/lc4_execute.sv
// Execute stage: operand bypass, ALU, NZP bypass and branch resolution
// Redirect and target go back to fetch and decode in the same cycle
`timescale 1ns/100ps
`default_nettype none

module lc4_execute
  import lc4_pkg::*;
(
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire dx_t   i_dx,
  input  wire xm_t   i_m_fwd,        // Instruction now in memory
  input  wire wb_t   i_w_fwd,        // Commit record
  input  wire word_t i_m_load_data,
  input  wire nzp_t  i_nzp,          // Architectural NZP
  output logic       o_redirect,
  output word_t      o_target,
  output xm_t        o_xm
);

  word_t    m_value;
  logic     m_writes;
  word_t    rs_val;
  word_t    rt_val;
  word_t    imm5;
  word_t    imm6;
  word_t    imm9;
  word_t    pc_plus_one;
  word_t    alu_result;
  nzp_t     nzp_cur;
  logic     taken;
  logic     xm_valid_q;
  ctrl_t    xm_ctrl_q;
  reg_idx_t xm_rd_q;
  word_t    xm_result_q;
  word_t    xm_store_data_q;

  // A load in memory forwards the data just read, not its address
  assign m_value  = i_m_fwd.ctrl.is_load ? i_m_load_data : i_m_fwd.result;
  assign m_writes = i_m_fwd.valid && i_m_fwd.ctrl.regfile_we;

  // Youngest producer wins
  assign rs_val = (m_writes && i_m_fwd.rd == i_dx.rs) ? m_value :
                  (i_w_fwd.regfile_we && i_w_fwd.wsel == i_dx.rs) ? i_w_fwd.data :
                  i_dx.rs_data;
  assign rt_val = (m_writes && i_m_fwd.rd == i_dx.rt) ? m_value :
                  (i_w_fwd.regfile_we && i_w_fwd.wsel == i_dx.rt) ? i_w_fwd.data :
                  i_dx.rt_data;

  assign imm5        = {{11{i_dx.insn[4]}}, i_dx.insn[4:0]};
  assign imm6        = {{10{i_dx.insn[5]}}, i_dx.insn[5:0]};
  assign imm9        = {{7{i_dx.insn[8]}}, i_dx.insn[8:0]};
  assign pc_plus_one = i_dx.pc + 16'd1;

  always_comb begin
    case (i_dx.ctrl.alu_op)
      ALU_ADD:     alu_result = rs_val + rt_val;
      ALU_SUB:     alu_result = rs_val - rt_val;
      ALU_ADDI:    alu_result = rs_val + imm5;
      ALU_AND:     alu_result = rs_val & rt_val;
      ALU_OR:      alu_result = rs_val | rt_val;
      ALU_XOR:     alu_result = rs_val ^ rt_val;
      ALU_NOT:     alu_result = ~rs_val;
      ALU_CONST:   alu_result = imm9;
      ALU_HICONST: alu_result = {i_dx.insn[7:0], rs_val[7:0]};
      ALU_ADDR:    alu_result = rs_val + imm6;
      default:     alu_result = rs_val;
    endcase
  end

  // NZP from the youngest older writer still in flight
  always_comb begin
    if (i_m_fwd.valid && i_m_fwd.ctrl.nzp_we) begin
      nzp_cur = nzp_of(m_value);
    end else if (i_w_fwd.nzp_we) begin
      nzp_cur = i_w_fwd.nzp;
    end else begin
      nzp_cur = i_nzp;
    end
  end

  assign taken      = |(i_dx.insn[11:9] & nzp_cur);  // BR with nzp 000 never taken
  assign o_redirect = i_dx.valid &&
                      ((i_dx.ctrl.is_branch && taken) || i_dx.ctrl.is_jump);
  assign o_target   = i_dx.ctrl.is_jump ? rs_val : pc_plus_one + imm9;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      xm_valid_q <= 1'b0;
      xm_ctrl_q  <= '0;
    end else begin
      xm_valid_q <= i_dx.valid;
      xm_ctrl_q  <= i_dx.ctrl;  // Already cleared for bubbles
    end
  end

  always_ff @(posedge gwe) begin
    xm_rd_q         <= i_dx.rd;
    xm_result_q     <= alu_result;
    xm_store_data_q <= rt_val;
  end

  assign o_xm = '{valid: xm_valid_q, rd: xm_rd_q, ctrl: xm_ctrl_q,
                  result: xm_result_q, store_data: xm_store_data_q};

endmodule

`default_nettype wire

//--- design/lc4_memory.sv
// Memory stage: data memory port, commit register and the NZP register
// Loads and stores complete combinationally inside the memory cycle
`timescale 1ns/100ps
`default_nettype none

module lc4_memory
  import lc4_pkg::*;
(
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire xm_t   i_xm,
  input  wire word_t i_dmem_rdata,
  output word_t      o_dmem_addr,
  output word_t      o_dmem_wdata,
  output logic       o_dmem_we,
  output word_t      o_load_data,   // Bypass to execute
  output wb_t        o_wb,
  output nzp_t       o_nzp
);

  logic     mem_op;
  word_t    wb_value;
  logic     wb_regfile_we_q;
  logic     wb_nzp_we_q;
  reg_idx_t wb_wsel_q;
  word_t    wb_data_q;
  nzp_t     wb_nzp_q;
  nzp_t     nzp_q;

  assign mem_op       = i_xm.valid && (i_xm.ctrl.is_load || i_xm.ctrl.is_store);
  assign o_dmem_addr  = mem_op ? i_xm.result : '0;  // Zero for non-memory instructions
  assign o_dmem_we    = i_xm.valid && i_xm.ctrl.is_store;
  assign o_dmem_wdata = i_xm.store_data;
  assign o_load_data  = i_dmem_rdata;
  assign wb_value     = i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.result;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      wb_regfile_we_q <= 1'b0;
      wb_nzp_we_q     <= 1'b0;
    end else begin
      wb_regfile_we_q <= i_xm.valid && i_xm.ctrl.regfile_we;
      wb_nzp_we_q     <= i_xm.valid && i_xm.ctrl.nzp_we;
    end
  end

  always_ff @(posedge gwe) begin
    wb_wsel_q <= i_xm.rd;
    wb_data_q <= wb_value;
    wb_nzp_q  <= nzp_of(wb_value);
  end

  // Architectural NZP, updated as the commit retires
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      nzp_q <= '0;
    end else if (wb_nzp_we_q) begin
      nzp_q <= wb_nzp_q;
    end
  end

  assign o_wb  = '{regfile_we: wb_regfile_we_q, wsel: wb_wsel_q, data: wb_data_q,
                   nzp_we: wb_nzp_we_q, nzp: wb_nzp_q};
  assign o_nzp = nzp_q;

endmodule

`default_nettype wire

//--- design/lc4_pipeline.sv
// Top level of the LC4 five-stage pipeline
// Connects the stages, the two memory ports and the commit trace
`timescale 1ns/100ps
`default_nettype none

module lc4_pipeline
  import lc4_pkg::*;
#(
  parameter word_t RESET_PC = 16'h8200
) (
  input  wire        gwe,
  input  wire        i_rst_n,
  output word_t      o_imem_addr,
  input  wire insn_t i_imem_data,
  output word_t      o_dmem_addr,
  input  wire word_t i_dmem_rdata,
  output logic       o_dmem_we,
  output word_t      o_dmem_wdata,
  output wb_t        o_commit
);

  fd_t   fd;
  dx_t   dx;
  xm_t   xm;
  wb_t   wb;
  logic  stall;
  logic  redirect;
  word_t target;
  word_t load_data;
  nzp_t  nzp;

  lc4_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .gwe         (gwe),
    .i_rst_n     (i_rst_n),
    .i_stall     (stall),
    .i_redirect  (redirect),
    .i_target    (target),
    .i_imem_data (i_imem_data),
    .o_imem_addr (o_imem_addr),
    .o_fd        (fd)
  );

  lc4_decode u_decode (
    .gwe         (gwe),
    .i_rst_n     (i_rst_n),
    .i_fd        (fd),
    .i_redirect  (redirect),
    .i_x_rd      (dx.rd),
    .i_x_is_load (dx.ctrl.is_load),
    .i_wb        (wb),
    .o_stall     (stall),
    .o_dx        (dx)
  );

  lc4_execute u_execute (
    .gwe           (gwe),
    .i_rst_n       (i_rst_n),
    .i_dx          (dx),
    .i_m_fwd       (xm),
    .i_w_fwd       (wb),
    .i_m_load_data (load_data),
    .i_nzp         (nzp),
    .o_redirect    (redirect),
    .o_target      (target),
    .o_xm          (xm)
  );

  lc4_memory u_memory (
    .gwe          (gwe),
    .i_rst_n      (i_rst_n),
    .i_xm         (xm),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_load_data  (load_data),
    .o_wb         (wb),
    .o_nzp        (nzp)
  );

  assign o_commit = wb;

endmodule

`default_nettype wire

//--- sim/lc4_commit_checker.sv
// Commit and store checker for the LC4 pipeline testbench
// The testbench fills the expected lists and this module pops them in order
`timescale 1ns/100ps
`default_nettype none

module lc4_commit_checker
  import lc4_pkg::*;
(
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire wb_t   i_commit,
  input  wire        i_dmem_we,
  input  wire word_t i_dmem_addr,
  input  wire word_t i_dmem_wdata,
  output int         o_mismatches,
  output int         o_extras,      // Events beyond the expected lists
  output int         o_pending      // Expected entries not seen yet
);

  reg_idx_t exp_wsel  [$];
  word_t    exp_data  [$];
  word_t    exp_saddr [$];
  word_t    exp_sdata [$];
  int       mismatch_cnt = 0;
  int       extra_cnt    = 0;

  task automatic expect_commit(input reg_idx_t wsel, input word_t data);
    exp_wsel.push_back(wsel);
    exp_data.push_back(data);
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_saddr.push_back(addr);
    exp_sdata.push_back(data);
  endtask

  // NZP from the sign of the committed value
  function automatic logic [2:0] sign_code(input word_t v);
    if ($signed(v) < 0) return 3'b100;
    if (v == 16'd0) return 3'b010;
    return 3'b001;
  endfunction

  task automatic compare(input string name, input logic [15:0] want,
                         input logic [15:0] got);
    if (got !== want) begin  // Also catches X and Z
      mismatch_cnt++;
      $display("ERROR %0d ns: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic check_commit();
    reg_idx_t want_wsel;
    word_t    want_data;
    if (exp_wsel.size() == 0) begin
      extra_cnt++;
      $display("ERROR %0d ns: commit to R%0d with %h arrived after the list ran out",
               $time, i_commit.wsel, i_commit.data);
    end else begin
      want_wsel = exp_wsel.pop_front();
      want_data = exp_data.pop_front();
      compare("o_commit.wsel", want_wsel, i_commit.wsel);
      compare("o_commit.data", want_data, i_commit.data);
      compare("o_commit.nzp_we", 16'd1, i_commit.nzp_we);  // Every register write sets NZP
      compare("o_commit.nzp", sign_code(want_data), i_commit.nzp);
    end
  endtask

  task automatic check_store();
    word_t want_addr;
    word_t want_data;
    if (exp_saddr.size() == 0) begin
      extra_cnt++;
      $display("ERROR %0d ns: store of %h to %h arrived after the list ran out",
               $time, i_dmem_wdata, i_dmem_addr);
    end else begin
      want_addr = exp_saddr.pop_front();
      want_data = exp_sdata.pop_front();
      compare("o_dmem_addr", want_addr, i_dmem_addr);
      compare("o_dmem_wdata", want_data, i_dmem_wdata);
    end
  endtask

  // Outputs are registered so readers see last edge's state
  always @(posedge gwe) begin
    if (i_rst_n) begin
      if (i_commit.regfile_we) check_commit();
      if (i_dmem_we) check_store();
    end
    o_mismatches <= mismatch_cnt;
    o_extras     <= extra_cnt;
    o_pending    <= exp_wsel.size() + exp_saddr.size();
  end

endmodule

`default_nettype wire

//--- sim/lc4_pipeline_tb.sv
// Testbench for the LC4 pipeline with program, data and expected results
// taken from sim/lc4_prog_input.txt, run until all expected entries appear
`timescale 1ns/100ps
`default_nettype none

module lc4_pipeline_tb
  import lc4_pkg::*;
();

  localparam word_t RESET_PC = 16'h8200;

  logic  gwe;
  logic  rst_n;
  word_t imem_addr;
  insn_t imem_data;
  word_t dmem_addr;
  word_t dmem_rdata;
  logic  dmem_we;
  word_t dmem_wdata;
  wb_t   commit;
  word_t imem [65536];
  word_t dmem [65536];
  int    n_words;
  int    load_errors;
  int    cycles;
  int    limit;
  int    mismatches;
  int    extras;
  int    pending;

  initial begin
    gwe = 1'b0;
    forever #20 gwe = ~gwe;  // 40 ns period
  end

  // Both memories answer in the same cycle
  assign imem_data  = imem[imem_addr];
  assign dmem_rdata = dmem[dmem_addr];

  always @(posedge gwe) begin
    if (dmem_we) dmem[dmem_addr] <= dmem_wdata;
  end

  lc4_pipeline #(
    .RESET_PC (RESET_PC)
  ) u_lc4_pipeline (
    .gwe          (gwe),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .o_commit     (commit)
  );

  lc4_commit_checker u_checker (
    .gwe          (gwe),
    .i_rst_n      (rst_n),
    .i_commit     (commit),
    .i_dmem_we    (dmem_we),
    .i_dmem_addr  (dmem_addr),
    .i_dmem_wdata (dmem_wdata),
    .o_mismatches (mismatches),
    .o_extras     (extras),
    .o_pending    (pending)
  );

  task automatic fill_memories();
    for (int i = 0; i < 65536; i++) begin
      imem[i] = i[15:0] ^ 16'hc35a;   // Unloaded program space holds address-derived junk
      dmem[i] = i[15:0] ^ 16'h5a3c;   // Differs from every stored value
    end
  endtask

  task automatic skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  // Tagged lines P, D, C and S carry two hex fields and # starts a comment
  task automatic load_input();
    int         fd;
    int         r;
    logic [7:0] tag;
    word_t      a;
    word_t      b;
    fd = $fopen("sim/lc4_prog_input.txt", "r");
    if (fd == 0) begin
      load_errors++;
      $display("Could not open sim/lc4_prog_input.txt");
      return;
    end
    r = $fscanf(fd, " %c", tag);
    while (r == 1) begin
      if (tag != "#") begin
        r = $fscanf(fd, "%h %h", a, b);
        if (r != 2) begin
          load_errors++;
          $display("Input line with tag %s lacks its two hex fields", tag);
        end
        case (tag)
          "P": begin
            imem[a] = b;
            n_words++;
          end
          "D": dmem[a] = b;
          "C": u_checker.expect_commit(a[2:0], b);
          "S": u_checker.expect_store(a, b);
          default: begin
            load_errors++;
            $display("Input line has unknown tag %s", tag);
          end
        endcase
      end
      skip_line(fd);  // Drops comments and trailing text
      r = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  initial begin
    rst_n       = 1'b0;
    n_words     = 0;
    load_errors = 0;
    cycles      = 0;
    fill_memories();
    load_input();
    limit = 20 * n_words + 50;  // Cycle budget per program word plus pipeline slack
    repeat (5) @(posedge gwe);
    rst_n <= 1'b1;
    while (pending != 0 && cycles < limit) begin
      @(posedge gwe);
      cycles++;
    end
    repeat (10) @(posedge gwe);  // Room for a stray late commit or store
    if (pending != 0) begin
      $display("Timed out after %0d cycles with %0d expected entries never seen",
               cycles, pending);
    end
    $display("Error counts: mismatch %0d, unexpected %0d, missing %0d, input file %0d",
             mismatches, extras, pending, load_errors);
    if (mismatches == 0 && extras == 0 && pending == 0 && load_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/lc4_prog_input.txt
# P addr insn | D addr data | C reg value (commit, in order) | S addr data (store, in order)
# All fields hex, text after the second field is ignored
P 8200 9205  # CONST R1, #5
P 8201 95FD  # CONST R2, #-3
P 8202 1642  # ADD R3, R1, R2     bypass from memory and writeback
P 8203 18D1  # SUB R4, R3, R1
P 8204 5B01  # AND R5, R4, R1
P 8205 5C93  # OR R6, R2, R3
P 8206 5F99  # XOR R7, R6, R1
P 8207 5148  # NOT R0, R5
P 8208 1267  # ADD R1, R1, #7
P 8209 9C40  # CONST R6, #0x40
P 820A DD40  # HICONST R6, #0x40
P 820B 6581  # LDR R2, R6, #1
P 820C 1681  # ADD R3, R2, R1     load-use
P 820D 7782  # STR R3, R6, #2
P 820E 6982  # LDR R4, R6, #2     reads the store back
P 820F 0802  # BRn +2             not taken, NZP from the load
P 8210 1B3F  # ADD R5, R4, #-1
P 8211 0202  # BRp +2             taken
P 8212 9001  # CONST R0, #1       shadow
P 8213 9002  # CONST R0, #2       shadow
P 8214 9E18  # CONST R7, #0x18
P 8215 DF82  # HICONST R7, #0x82
P 8216 C1C0  # JMPR R7            to 8218
P 8217 9003  # CONST R0, #3       shadow
P 8218 7B83  # STR R5, R6, #3
P 8219 93FF  # CONST R1, #-1
P 821A 0FFF  # BRnzp -1           parks the program
D 4041 1234
C 1 0005
C 2 FFFD
C 3 0002
C 4 FFFD
C 5 0005
C 6 FFFF
C 7 FFFA
C 0 FFFA
C 1 000C
C 6 0040
C 6 4040
C 2 1234
C 3 1240
S 4042 1240
C 4 1240
C 5 123F
C 7 0018
C 7 8218
S 4043 123F
C 1 FFFF

//--- lc4_pipeline.f
design/lc4_pkg.sv
design/lc4_regfile.sv
design/lc4_fetch.sv
design/lc4_decode.sv
design/lc4_execute.sv
design/lc4_memory.sv
design/lc4_pipeline.sv
sim/lc4_commit_checker.sv
sim/lc4_pipeline_tb.sv

//--- Bender.yml
package:
  name: lc4_pipeline

sources:
  - files:
      - design/lc4_pkg.sv
      - design/lc4_regfile.sv
      - design/lc4_fetch.sv
      - design/lc4_decode.sv
      - design/lc4_execute.sv
      - design/lc4_memory.sv
      - design/lc4_pipeline.sv
  - target: simulation
    files:
      - sim/lc4_commit_checker.sv
      - sim/lc4_pipeline_tb.sv
